/* logic/exc_cfg.svh */
`ifndef EXC_CFG_SVH
`define EXC_CFG_SVH

// Width of the exception vector code
// Set by the architecture's vector table, eight slots
`define EXC_VECTOR_W 3

// Width of the PC offset select sent to the link register path
`define EXC_PCSEL_W 2

// Vector slot taken on reset
`define EXC_RESET_VECTOR 0

`endif

/* logic/excPkg.sv */
`default_nettype none

`include "exc_cfg.svh"

package excPkg;

  // Sequencer states
  // Interrupt path walks the last instruction from execute to writeback
  typedef enum logic [2:0] {
    ready,
    dataAbort2,
    intE,
    intM,
    intW,
    exceptionM,
    exceptionW
  } excState;

  // Exceptions detected in execute, carried down the pipe
  typedef struct packed {
    logic undefinedInstr;
    logic swi;
    logic prefetchAbort;
  } excFlags;

  // One bit per stage, decode first
  typedef struct packed {
    logic decode;
    logic execute;
    logic memory;
    logic writeback;
  } stageStall;

  // Same layout as the stall set
  typedef struct packed {
    logic decode;
    logic execute;
    logic memory;
    logic writeback;
  } stageFlush;

  // Slot in the vector table
  // Slot 5 is unused
  typedef enum logic [`EXC_VECTOR_W-1:0] {
    vecReset         = `EXC_VECTOR_W'(`EXC_RESET_VECTOR),
    vecUndefined     = `EXC_VECTOR_W'(1),
    vecSwi           = `EXC_VECTOR_W'(2),
    vecPrefetchAbort = `EXC_VECTOR_W'(3),
    vecDataAbort     = `EXC_VECTOR_W'(4),
    vecIrq           = `EXC_VECTOR_W'(6),
    vecFiq           = `EXC_VECTOR_W'(7)
  } vectorCode;

  // Offset from the decode PC that goes to the link register
  typedef enum logic [`EXC_PCSEL_W-1:0] {
    pcPlus8 = `EXC_PCSEL_W'(0),
    pcPlus0 = `EXC_PCSEL_W'(1),
    pcPlus4 = `EXC_PCSEL_W'(2)
  } pcSource;

endpackage

`default_nettype wire

/* logic/excStageTrack.sv */
`timescale 1ns/1ps
`default_nettype none

module excStageTrack (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire excPkg::excFlags   excE,
  input  wire excPkg::stageStall stall,
  input  wire logic              irq,
  input  wire logic              fiq,
  input  wire logic              irqEnabled,
  input  wire logic              fiqEnabled,
  input  wire logic              pcUpdateW,
  input  wire logic              interrupting,
  input  wire logic              inExceptionM,
  output excPkg::excFlags        excW,
  output logic                   irqPending,
  output logic                   fiqPending,
  output logic                   unstallDecode
);

  // Flags sitting in memory
  excPkg::excFlags excM;

  // Enables after the one-cycle resync
  logic irqEnSync;
  logic fiqEnSync;

  // Memory copy of the execute flags
  // Dropped once the sequencer has left ready, some other event got there first
  always_ff @(posedge clk) begin
    if (reset) begin
      excM <= '0;
    end else if (!stall.memory) begin
      if (interrupting) begin
        excM <= '0;
      end else begin
        excM <= excE;
      end
    end
  end

  // Writeback copy, only kept while the exception is moving through memory
  // So status is saved after the last good instruction has set its flags
  always_ff @(posedge clk) begin
    if (reset) begin
      excW <= '0;
    end else if (!stall.writeback) begin
      if (!inExceptionM) begin
        excW <= '0;
      end else begin
        excW <= excM;
      end
    end
  end

  // Status register updates late in the cycle
  // Delay the enables so they change on the next rising edge
  always_ff @(posedge clk) begin
    if (reset) begin
      irqEnSync <= 1'b0;
      fiqEnSync <= 1'b0;
    end else begin
      irqEnSync <= irqEnabled;
      fiqEnSync <= fiqEnabled;
    end
  end

  // A PC write reached writeback, let the branch target into decode
  always_ff @(posedge clk) begin
    if (reset) begin
      unstallDecode <= 1'b0;
    end else if (!stall.execute) begin
      unstallDecode <= pcUpdateW;
    end
  end

  // Requests masked by the synced enables
  assign irqPending = irq & irqEnSync;
  assign fiqPending = fiq & fiqEnSync;

endmodule

`default_nettype wire

/* logic/excFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module excFsm (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire excPkg::excFlags   excE,
  input  wire logic              dataAbort,
  input  wire logic              irqPending,
  input  wire logic              fiqPending,
  input  wire excPkg::stageStall stall,
  input  wire logic              pcWrPendingF,
  input  wire logic              unstallDecode,
  output excPkg::stageFlush      flush,
  output logic                   stallDecode,
  output logic                   interrupting,
  output logic                   inExceptionM,
  output logic                   dataAbortCycle2,
  output logic                   irqAssert,
  output logic                   fiqAssert,
  output logic                   resetMicrop
);

  excPkg::excState state;
  excPkg::excState nextState;

  // Any execute-stage exception
  logic excAnyE;

  // Either interrupt still requested
  logic intPending;

  assign excAnyE    = excE.undefinedInstr | excE.swi | excE.prefetchAbort;
  assign intPending = irqPending | fiqPending;

  // State register
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= excPkg::ready;
    end else begin
      state <= nextState;
    end
  end

  // Next state and flush pattern
  // Flush bits are decode, execute, memory, writeback
  always_comb begin
    flush     = 4'b0000;
    nextState = state;
    case (state)
      excPkg::ready: begin
        if (dataAbort) begin
          // Seen in memory, wipe everything behind and ahead of it
          flush     = 4'b1111;
          nextState = excPkg::dataAbort2;
        end else if (excAnyE) begin
          // Seen in execute
          // Status is saved later so the older instruction can still set flags
          flush     = 4'b1110;
          nextState = stall.memory ? excPkg::ready : excPkg::exceptionM;
        end else if (intPending) begin
          // Let the last instruction leave decode first
          flush     = 4'b0000;
          nextState = stall.decode ? excPkg::ready : excPkg::intE;
        end else begin
          flush     = 4'b0000;
          nextState = excPkg::ready;
        end
      end

      excPkg::dataAbort2: begin
        // Save the PC this cycle and drop what was fetched
        flush     = 4'b1011;
        nextState = excPkg::ready;
      end

      excPkg::exceptionM: begin
        flush     = 4'b1111;
        nextState = stall.writeback ? excPkg::exceptionM : excPkg::exceptionW;
      end

      excPkg::exceptionW: begin
        // Writeback flags select the vector now
        flush     = 4'b1011;
        nextState = excPkg::ready;
      end

      excPkg::intE: begin
        // Hold while a PC write is still on its way, those stall everything
        flush = 4'b0100;
        if (!intPending) begin
          nextState = excPkg::ready;
        end else if (stall.execute || pcWrPendingF) begin
          nextState = excPkg::intE;
        end else begin
          nextState = excPkg::intM;
        end
      end

      excPkg::intM: begin
        flush = 4'b0100;
        if (!intPending) begin
          nextState = excPkg::ready;
        end else if (stall.memory) begin
          nextState = excPkg::intM;
        end else begin
          nextState = excPkg::intW;
        end
      end

      excPkg::intW: begin
        // Last instruction in writeback, interrupt is raised here
        flush = 4'b1000;
        if (intPending && stall.writeback) begin
          nextState = excPkg::intW;
        end else begin
          nextState = excPkg::ready;
        end
      end

      default: begin
        flush     = 4'b0000;
        nextState = excPkg::ready;
      end
    endcase
  end

  // State decodes shared with the tracker and the vector encoder
  assign interrupting    = state != excPkg::ready;
  assign inExceptionM    = state == excPkg::exceptionM;
  assign dataAbortCycle2 = state == excPkg::dataAbort2;

  // FIQ wins when both are pending
  assign fiqAssert = (state == excPkg::intW) & fiqPending;
  assign irqAssert = (state == excPkg::intW) & irqPending & ~fiqAssert;

  // Decode normally holds so the next fetch address is kept
  // After a branch the target must reach decode, hence the unstall in intM
  assign stallDecode = (state == excPkg::intE)
                     | ((state == excPkg::intM) & ~unstallDecode)
                     | ((state == excPkg::ready) & (dataAbort | excAnyE))
                     | (state == excPkg::exceptionM);

  // Abort the microop sequence along with the data access
  assign resetMicrop = dataAbort;

endmodule

`default_nettype wire

/* logic/excVector.sv */
`timescale 1ns/1ps
`default_nettype none

module excVector (
  input  wire logic            reset,
  input  wire excPkg::excFlags excW,
  input  wire logic            dataAbortCycle2,
  input  wire logic            irqAssert,
  input  wire logic            fiqAssert,
  output excPkg::vectorCode    vectorPc,
  output logic                 savePc,
  output excPkg::pcSource      pcSelect
);

  // Any exception flag that made it to writeback
  logic excAnyW;

  assign excAnyW = excW.undefinedInstr | excW.swi | excW.prefetchAbort;

  // Highest priority source picks the slot
  always_comb begin
    if (reset) begin
      vectorPc = excPkg::vecReset;
    end else if (dataAbortCycle2) begin
      vectorPc = excPkg::vecDataAbort;
    end else if (fiqAssert) begin
      vectorPc = excPkg::vecFiq;
    end else if (irqAssert) begin
      vectorPc = excPkg::vecIrq;
    end else if (excW.prefetchAbort) begin
      vectorPc = excPkg::vecPrefetchAbort;
    end else if (excW.undefinedInstr) begin
      vectorPc = excPkg::vecUndefined;
    end else if (excW.swi) begin
      vectorPc = excPkg::vecSwi;
    end else begin
      // Nothing active, save strobe is low so the slot is ignored
      vectorPc = excPkg::vecReset;
    end
  end

  // Redirect the PC whenever any source is active
  assign savePc = reset | dataAbortCycle2 | fiqAssert | irqAssert | excAnyW;

  // Link register offset
  always_comb begin
    if (irqAssert || fiqAssert) begin
      // Return to the instruction still waiting in decode
      pcSelect = excPkg::pcPlus4;
    end else if (excAnyW || dataAbortCycle2) begin
      pcSelect = excPkg::pcPlus0;
    end else begin
      // Normal flow
      pcSelect = excPkg::pcPlus8;
    end
  end

endmodule

`default_nettype wire

/* logic/excControl.sv */
`timescale 1ns/1ps
`default_nettype none

module excControl (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire excPkg::excFlags   excE,
  input  wire logic              dataAbort,
  input  wire logic              irq,
  input  wire logic              fiq,
  input  wire logic              irqEnabled,
  input  wire logic              fiqEnabled,
  input  wire excPkg::stageStall stall,
  input  wire logic              pcWrPendingF,
  input  wire logic              pcUpdateW,
  output excPkg::excFlags        excW,
  output excPkg::stageFlush      flush,
  output logic                   stallDecode,
  output logic                   interrupting,
  output logic                   dataAbortCycle2,
  output logic                   irqAssert,
  output logic                   fiqAssert,
  output logic                   resetMicrop,
  output excPkg::vectorCode      vectorPc,
  output logic                   savePc,
  output excPkg::pcSource        pcSelect
);

  // Masked requests and branch unstall from the tracker
  logic irqPending;
  logic fiqPending;
  logic unstallDecode;

  // Flag register clear from the sequencer
  logic inExceptionM;

  // Stage carry and enable sync
  excStageTrack excStageTrack_i (
    .clk          (clk),
    .reset        (reset),
    .excE         (excE),
    .stall        (stall),
    .irq          (irq),
    .fiq          (fiq),
    .irqEnabled   (irqEnabled),
    .fiqEnabled   (fiqEnabled),
    .pcUpdateW    (pcUpdateW),
    .interrupting (interrupting),
    .inExceptionM (inExceptionM),
    .excW         (excW),
    .irqPending   (irqPending),
    .fiqPending   (fiqPending),
    .unstallDecode(unstallDecode)
  );

  // Sequencer
  excFsm excFsm_i (
    .clk            (clk),
    .reset          (reset),
    .excE           (excE),
    .dataAbort      (dataAbort),
    .irqPending     (irqPending),
    .fiqPending     (fiqPending),
    .stall          (stall),
    .pcWrPendingF   (pcWrPendingF),
    .unstallDecode  (unstallDecode),
    .flush          (flush),
    .stallDecode    (stallDecode),
    .interrupting   (interrupting),
    .inExceptionM   (inExceptionM),
    .dataAbortCycle2(dataAbortCycle2),
    .irqAssert      (irqAssert),
    .fiqAssert      (fiqAssert),
    .resetMicrop    (resetMicrop)
  );

  // Vector and link offset
  excVector excVector_i (
    .reset          (reset),
    .excW           (excW),
    .dataAbortCycle2(dataAbortCycle2),
    .irqAssert      (irqAssert),
    .fiqAssert      (fiqAssert),
    .vectorPc       (vectorPc),
    .savePc         (savePc),
    .pcSelect       (pcSelect)
  );

endmodule

`default_nettype wire

/* bench/excControlModel.svh */
`ifndef EXC_CONTROL_MODEL_SVH
`define EXC_CONTROL_MODEL_SVH

// Every DUT output that the comparison process checks
typedef struct packed {
  excPkg::stageFlush flush;
  logic              stallDecode;
  logic              interrupting;
  logic              dataAbortCycle2;
  logic              irqAssert;
  logic              fiqAssert;
  logic              resetMicrop;
  excPkg::vectorCode vectorPc;
  logic              savePc;
  excPkg::pcSource   pcSelect;
  excPkg::excFlags   excW;
} expectSet;

// Cycle model registers starting at their reset values
excPkg::excState mState = excPkg::ready;
excPkg::excFlags mExcM = '0;
excPkg::excFlags mExcW = '0;
logic mIrqEn = 1'b0;
logic mFiqEn = 1'b0;
logic mUnstall = 1'b0;

// Expected outputs for this cycle before the model advances by one edge
function automatic expectSet excModelStep(input logic rst, input stimSet s);
  expectSet e;
  excPkg::excState nxt;
  excPkg::excFlags nextExcW;
  logic irqP;
  logic fiqP;
  logic intP;
  logic anyW;
  e = '0;
  irqP = s.irq & mIrqEn;
  fiqP = s.fiq & mFiqEn;
  intP = irqP | fiqP;
  anyW = |mExcW;
  nxt = excPkg::ready;
  e.excW = mExcW;
  e.resetMicrop = s.dataAbort;
  e.interrupting = (mState != excPkg::ready);
  e.dataAbortCycle2 = (mState == excPkg::dataAbort2);
  case (mState)
    excPkg::ready: begin
      // Data abort first, then execute exceptions, then interrupts
      if (s.dataAbort) begin
        e.flush = 4'b1111;
        e.stallDecode = 1'b1;
        nxt = excPkg::dataAbort2;
      end else if (|s.excE) begin
        e.flush = 4'b1110;
        e.stallDecode = 1'b1;
        nxt = s.stall.memory ? excPkg::ready : excPkg::exceptionM;
      end else if (intP && !s.stall.decode) begin
        nxt = excPkg::intE;
      end
    end
    excPkg::dataAbort2: e.flush = 4'b1011;
    excPkg::exceptionM: begin
      e.flush = 4'b1111;
      e.stallDecode = 1'b1;
      nxt = s.stall.writeback ? excPkg::exceptionM : excPkg::exceptionW;
    end
    excPkg::exceptionW: e.flush = 4'b1011;
    excPkg::intE: begin
      e.flush = 4'b0100;
      e.stallDecode = 1'b1;
      if (intP) begin
        nxt = (s.stall.execute || s.pcWrPendingF) ? excPkg::intE : excPkg::intM;
      end
    end
    excPkg::intM: begin
      e.flush = 4'b0100;
      e.stallDecode = !mUnstall;
      if (intP) begin
        nxt = s.stall.memory ? excPkg::intM : excPkg::intW;
      end
    end
    excPkg::intW: begin
      e.flush = 4'b1000;
      e.fiqAssert = fiqP;
      e.irqAssert = irqP & !fiqP;
      nxt = (intP && s.stall.writeback) ? excPkg::intW : excPkg::ready;
    end
    default: nxt = excPkg::ready;
  endcase
  // Vector priority with reset highest
  if (rst) e.vectorPc = excPkg::vecReset;
  else if (e.dataAbortCycle2) e.vectorPc = excPkg::vecDataAbort;
  else if (e.fiqAssert) e.vectorPc = excPkg::vecFiq;
  else if (e.irqAssert) e.vectorPc = excPkg::vecIrq;
  else if (mExcW.prefetchAbort) e.vectorPc = excPkg::vecPrefetchAbort;
  else if (mExcW.undefinedInstr) e.vectorPc = excPkg::vecUndefined;
  else if (mExcW.swi) e.vectorPc = excPkg::vecSwi;
  else e.vectorPc = excPkg::vecReset;
  e.savePc = rst | e.dataAbortCycle2 | e.fiqAssert | e.irqAssert | anyW;
  if (e.irqAssert || e.fiqAssert) e.pcSelect = excPkg::pcPlus4;
  else if (anyW || e.dataAbortCycle2) e.pcSelect = excPkg::pcPlus0;
  else e.pcSelect = excPkg::pcPlus8;
  // Writeback copy takes the old memory copy
  nextExcW = mExcW;
  if (!s.stall.writeback) begin
    nextExcW = (mState == excPkg::exceptionM) ? mExcM : '0;
  end
  if (rst) begin
    mState = excPkg::ready;
    mExcM = '0;
    mExcW = '0;
    mIrqEn = 1'b0;
    mFiqEn = 1'b0;
    mUnstall = 1'b0;
  end else begin
    if (!s.stall.memory) begin
      mExcM = e.interrupting ? excPkg::excFlags'(3'b000) : s.excE;
    end
    if (!s.stall.execute) begin
      mUnstall = s.pcUpdateW;
    end
    mExcW = nextExcW;
    mState = nxt;
    mIrqEn = s.irqEnabled;
    mFiqEn = s.fiqEnabled;
  end
  return e;
endfunction

`endif

/* bench/excControlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module excControlTb;

  // DUT inputs other than clock and reset
  typedef struct packed {
    excPkg::excFlags   excE;
    logic              dataAbort;
    logic              irq;
    logic              fiq;
    logic              irqEnabled;
    logic              fiqEnabled;
    excPkg::stageStall stall;
    logic              pcWrPendingF;
    logic              pcUpdateW;
  } stimSet;

  logic clk = 1'b0;
  logic reset;
  stimSet stim;

  // DUT outputs
  excPkg::excFlags   excW;
  excPkg::stageFlush flush;
  logic              stallDecode;
  logic              interrupting;
  logic              dataAbortCycle2;
  logic              irqAssert;
  logic              fiqAssert;
  logic              resetMicrop;
  excPkg::vectorCode vectorPc;
  logic              savePc;
  excPkg::pcSource   pcSelect;

  logic checkOn = 1'b0;
  string testName = "reset";
  logic [31:0] lcgState = 32'd91;

  `include "excControlModel.svh"

  expectSet expNow;

  excControl excControl_i (
    .clk            (clk),
    .reset          (reset),
    .excE           (stim.excE),
    .dataAbort      (stim.dataAbort),
    .irq            (stim.irq),
    .fiq            (stim.fiq),
    .irqEnabled     (stim.irqEnabled),
    .fiqEnabled     (stim.fiqEnabled),
    .stall          (stim.stall),
    .pcWrPendingF   (stim.pcWrPendingF),
    .pcUpdateW      (stim.pcUpdateW),
    .excW           (excW),
    .flush          (flush),
    .stallDecode    (stallDecode),
    .interrupting   (interrupting),
    .dataAbortCycle2(dataAbortCycle2),
    .irqAssert      (irqAssert),
    .fiqAssert      (fiqAssert),
    .resetMicrop    (resetMicrop),
    .vectorPc       (vectorPc),
    .savePc         (savePc),
    .pcSelect       (pcSelect)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      failRun($sformatf("mismatch %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic waitInterrupting(input logic level, input int limit);
    int n;
    n = 0;
    while (interrupting !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (interrupting !== level) begin
      failRun("timeout waiting for the sequencer to change state");
    end
  endtask

  task automatic waitAssert(input int limit);
    int n;
    n = 0;
    while (!(irqAssert || fiqAssert) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!(irqAssert || fiqAssert)) begin
      failRun("timeout waiting for an interrupt to be asserted");
    end
  endtask

  // Three fixed cycles with no stalls
  task automatic runException(input string name, input excPkg::excFlags f,
                              input excPkg::vectorCode v);
    nextCycle();
    testName = name;
    stim.excE = f;
    @(negedge clk);
    checkValue({name, " flush E"}, 4'b1110, flush);
    checkValue({name, " stallDecode E"}, 1, stallDecode);
    nextCycle();
    stim.excE = '0;
    @(negedge clk);
    checkValue({name, " flush M"}, 4'b1111, flush);
    checkValue({name, " stallDecode M"}, 1, stallDecode);
    nextCycle();
    @(negedge clk);
    checkValue({name, " flush W"}, 4'b1011, flush);
    checkValue({name, " excW"}, f, excW);
    checkValue({name, " vectorPc"}, v, vectorPc);
    checkValue({name, " savePc"}, 1, savePc);
    checkValue({name, " pcSelect"}, excPkg::pcPlus0, pcSelect);
    nextCycle();
    @(negedge clk);
    checkValue({name, " back to ready"}, 0, interrupting);
  endtask

  // Model and DUT compared in the middle of every cycle
  always @(negedge clk) begin
    if (checkOn) begin
      expNow = excModelStep(reset, stim);
      checkValue({testName, " flush"}, expNow.flush, flush);
      checkValue({testName, " stallDecode"}, expNow.stallDecode, stallDecode);
      checkValue({testName, " interrupting"}, expNow.interrupting, interrupting);
      checkValue({testName, " dataAbortCycle2"}, expNow.dataAbortCycle2, dataAbortCycle2);
      checkValue({testName, " irqAssert"}, expNow.irqAssert, irqAssert);
      checkValue({testName, " fiqAssert"}, expNow.fiqAssert, fiqAssert);
      checkValue({testName, " resetMicrop"}, expNow.resetMicrop, resetMicrop);
      checkValue({testName, " vectorPc"}, expNow.vectorPc, vectorPc);
      checkValue({testName, " savePc"}, expNow.savePc, savePc);
      checkValue({testName, " pcSelect"}, expNow.pcSelect, pcSelect);
      checkValue({testName, " excW"}, expNow.excW, excW);
    end
  end

  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    reset = 1'b1;
    stim = '0;
    @(posedge clk);
    checkOn = 1'b1;
    @(negedge clk);
    checkValue("reset savePc", 1, savePc);
    checkValue("reset vectorPc", excPkg::vecReset, vectorPc);
    // 16 cycles of reset in total
    repeat (15) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    checkValue("after reset flush", 0, flush);
    checkValue("after reset stallDecode", 0, stallDecode);
    checkValue("after reset interrupting", 0, interrupting);
    checkValue("after reset asserts", 0, {irqAssert, fiqAssert});
    checkValue("after reset savePc", 0, savePc);

    runException("swi", 3'b010, excPkg::vecSwi);
    runException("undefined", 3'b100, excPkg::vecUndefined);
    runException("prefetch abort", 3'b001, excPkg::vecPrefetchAbort);

    // Data abort over two cycles
    nextCycle();
    testName = "data abort";
    stim.dataAbort = 1'b1;
    @(negedge clk);
    checkValue("data abort resetMicrop", 1, resetMicrop);
    checkValue("data abort flush", 4'b1111, flush);
    nextCycle();
    stim.dataAbort = 1'b0;
    @(negedge clk);
    checkValue("data abort cycle 2", 1, dataAbortCycle2);
    checkValue("data abort vectorPc", excPkg::vecDataAbort, vectorPc);
    checkValue("data abort pcSelect", excPkg::pcPlus0, pcSelect);
    checkValue("data abort flush 2", 4'b1011, flush);

    // IRQ with the enable seen one cycle late
    nextCycle();
    testName = "irq";
    stim.irq = 1'b1;
    stim.irqEnabled = 1'b1;
    stim.fiqEnabled = 1'b1;
    @(negedge clk);
    nextCycle();
    @(negedge clk);
    checkValue("irq enable late", 0, interrupting);
    nextCycle();
    @(negedge clk);
    checkValue("irq intE", 1, interrupting);
    checkValue("irq intE flush", 4'b0100, flush);
    nextCycle();
    @(negedge clk);
    checkValue("irq intM flush", 4'b0100, flush);
    checkValue("irq intM assert", 0, irqAssert);
    nextCycle();
    @(negedge clk);
    checkValue("irq intW assert", 1, irqAssert);
    checkValue("irq vectorPc", excPkg::vecIrq, vectorPc);
    checkValue("irq pcSelect", excPkg::pcPlus4, pcSelect);
    checkValue("irq flush", 4'b1000, flush);
    nextCycle();
    stim.irq = 1'b0;
    waitInterrupting(1'b0, 4);

    // FIQ beats IRQ
    nextCycle();
    testName = "fiq over irq";
    stim.irq = 1'b1;
    stim.fiq = 1'b1;
    @(negedge clk);
    waitAssert(10);
    checkValue("fiq assert", 1, fiqAssert);
    checkValue("fiq irq held off", 0, irqAssert);
    checkValue("fiq vectorPc", excPkg::vecFiq, vectorPc);
    checkValue("fiq pcSelect", excPkg::pcPlus4, pcSelect);
    nextCycle();
    stim.irq = 1'b0;
    stim.fiq = 1'b0;
    waitInterrupting(1'b0, 4);

    // Request dropped in intM, sequencer goes straight back to ready
    nextCycle();
    testName = "irq dropped";
    stim.irq = 1'b1;
    @(negedge clk);
    waitInterrupting(1'b1, 6);
    nextCycle();
    stim.irq = 1'b0;
    @(negedge clk);
    checkValue("dropped irqAssert", 0, irqAssert);
    nextCycle();
    @(negedge clk);
    checkValue("dropped back to ready", 0, interrupting);
    checkValue("dropped irqAssert at end", 0, irqAssert);

    // Random phase with the model checking every cycle
    testName = "random";
    for (int i = 0; i < 2000; i++) begin
      nextCycle();
      lcgState = lcgNext(lcgState);
      r1 = lcgState;
      lcgState = lcgNext(lcgState);
      r2 = lcgState;
      stim.stall.decode = (r1[10:8] == 3'd0);
      stim.stall.execute = (r1[13:11] == 3'd0);
      stim.stall.memory = (r1[16:14] == 3'd0);
      stim.stall.writeback = (r1[19:17] == 3'd0);
      case (r1[23:20])
        4'd0: stim.excE = 3'b100;
        4'd1: stim.excE = 3'b010;
        4'd2: stim.excE = 3'b001;
        default: stim.excE = 3'b000;
      endcase
      stim.dataAbort = (r1[27:24] == 4'd0);
      // Interrupt lines and enables hold for a few cycles
      if (r1[29:28] == 2'd0) stim.irq = ~stim.irq;
      if (r1[31:30] == 2'd0) stim.fiq = ~stim.fiq;
      if (r2[12:9] == 4'd0) stim.irqEnabled = ~stim.irqEnabled;
      if (r2[16:13] == 4'd0) stim.fiqEnabled = ~stim.fiqEnabled;
      stim.pcWrPendingF = (r2[18:17] == 2'd0);
      stim.pcUpdateW = (r2[21:19] == 3'd0);
    end
    @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* excControl.f */
+incdir+logic
+incdir+bench
logic/excPkg.sv
logic/excStageTrack.sv
logic/excFsm.sv
logic/excVector.sv
logic/excControl.sv
bench/excControlTb.sv

/* Bender.yml */
package:
  name: excControl

sources:
  - include_dirs:
      - logic
    files:
      - logic/excPkg.sv
      - logic/excStageTrack.sv
      - logic/excFsm.sv
      - logic/excVector.sv
      - logic/excControl.sv
  - target: test
    include_dirs:
      - logic
      - bench
    files:
      - bench/excControlTb.sv
